//--- src/rx_pkg.sv
`default_nettype none

package rx_pkg;

    // ----------------------------------------
    // sample and phase widths
    // ----------------------------------------
    localparam int IQ_W    = 16;
    localparam int PHASE_W = 20;
    localparam int ID_W    = 32;

    typedef logic signed [IQ_W-1:0] iq_t;
    typedef logic [PHASE_W-1:0]     phase_t;
    typedef logic [ID_W-1:0]        sample_id_t;

    // ----------------------------------------
    // nco table
    // ----------------------------------------
    localparam int  LUT_BITS  = 6;
    localparam int  LUT_SIZE  = 1 << LUT_BITS;
    localparam int  FRAC_BITS = 15;
    localparam int  LUT_AMPL  = 32767;
    localparam real PI        = 3.14159265358979323846;

    typedef logic [LUT_BITS-1:0] lut_idx_t;

    // ----------------------------------------
    // status register map
    // ----------------------------------------
    localparam int REG_ADDR_W = 2;
    localparam int REG_DATA_W = 32;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    localparam reg_addr_t REG_SAMPLE_CNT = 2'd0;
    localparam reg_addr_t REG_CFO_INC    = 2'd1;
    localparam reg_addr_t REG_PHASE      = 2'd2;
    // Q in the upper half, I in the lower half
    localparam reg_addr_t REG_LAST_IQ    = 2'd3;

endpackage

`default_nettype wire

//--- src/rx_stream_if.sv
`timescale 1ns/1ns
`default_nettype none

// sample with its phase, from the accumulator to the nco
interface sample_phase_if;
    logic               valid;
    rx_pkg::iq_t        i;
    rx_pkg::iq_t        q;
    rx_pkg::phase_t     phase;
    rx_pkg::sample_id_t id;

    modport src (
        output valid, i, q, phase, id
    );

    modport dst (
        input valid, i, q, phase, id
    );
endinterface

// sample with its rotation vector, from the nco to the derotator
interface rotation_if;
    logic               valid;
    rx_pkg::iq_t        i;
    rx_pkg::iq_t        q;
    rx_pkg::iq_t        cos;
    rx_pkg::iq_t        sin;
    rx_pkg::sample_id_t id;

    modport src (
        output valid, i, q, cos, sin, id
    );

    modport dst (
        input valid, i, q, cos, sin, id
    );
endinterface

`default_nettype wire

//--- src/cfo_phase_accum.sv
`timescale 1ns/1ns
`default_nettype none

module cfo_phase_accum (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,

    input  wire logic               in_valid_i,
    input  wire rx_pkg::iq_t        in_i_i,
    input  wire rx_pkg::iq_t        in_q_i,

    input  wire logic               cfo_valid_i,
    input  wire rx_pkg::phase_t     cfo_update_i,
    input  wire logic               manual_mode_i,

    sample_phase_if.src             sp,

    output rx_pkg::phase_t          cfo_inc_o,
    output rx_pkg::phase_t          phase_o,
    output rx_pkg::sample_id_t      sample_cnt_o
);

    rx_pkg::sample_id_t sample_cnt;
    rx_pkg::phase_t     cfo_inc;
    rx_pkg::phase_t     phase;

    // ----------------------------------------
    // count, increment and phase
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt <= '0;
            cfo_inc    <= '0;
            phase      <= '0;
            sp.valid   <= 1'b0;
        end else begin
            sp.valid <= in_valid_i;
            if (in_valid_i) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            if (manual_mode_i) begin
                // manual cfo mode, no correction
                cfo_inc <= '0;
                phase   <= '0;
            end else begin
                // updates are relative to the last estimate
                if (cfo_valid_i) begin
                    cfo_inc <= cfo_inc - cfo_update_i;
                end
                if (in_valid_i) begin
                    phase <= phase + cfo_inc;
                end
            end
        end
    end

    // sample payload with the phase before the advance
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            sp.i     <= in_i_i;
            sp.q     <= in_q_i;
            sp.phase <= phase;
            sp.id    <= sample_cnt;
        end
    end

    assign cfo_inc_o    = cfo_inc;
    assign phase_o      = phase;
    assign sample_cnt_o = sample_cnt;

endmodule

`default_nettype wire

//--- src/nco_lut.sv
`timescale 1ns/1ns
`default_nettype none

module nco_lut (
    input  wire logic   clk_i,
    input  wire logic   reset_ni,

    sample_phase_if.dst sp,
    rotation_if.src     rot
);

    rx_pkg::iq_t      cos_tab [rx_pkg::LUT_SIZE];
    rx_pkg::iq_t      sin_tab [rx_pkg::LUT_SIZE];
    rx_pkg::lut_idx_t idx;

    // ----------------------------------------
    // table, one full turn in LUT_SIZE steps
    // ----------------------------------------
    for (genvar k = 0; k < rx_pkg::LUT_SIZE; k++) begin : g_tab
        // int' rounds to nearest
        assign cos_tab[k] = rx_pkg::iq_t'(int'(rx_pkg::LUT_AMPL *
                            $cos(2.0 * rx_pkg::PI * k / rx_pkg::LUT_SIZE)));
        assign sin_tab[k] = rx_pkg::iq_t'(int'(rx_pkg::LUT_AMPL *
                            $sin(2.0 * rx_pkg::PI * k / rx_pkg::LUT_SIZE)));
    end

    // top phase bits pick the entry
    assign idx = sp.phase[rx_pkg::PHASE_W-1 -: rx_pkg::LUT_BITS];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rot.valid <= 1'b0;
        end else begin
            rot.valid <= sp.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sp.valid) begin
            rot.cos <= cos_tab[idx];
            rot.sin <= sin_tab[idx];
            rot.i   <= sp.i;
            rot.q   <= sp.q;
            rot.id  <= sp.id;
        end
    end

endmodule

`default_nettype wire

//--- src/derotator.sv
`timescale 1ns/1ns
`default_nettype none

module derotator (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,

    rotation_if.dst                 rot,

    output logic                    out_valid_o,
    output rx_pkg::iq_t             out_i_o,
    output rx_pkg::iq_t             out_q_o,
    output rx_pkg::sample_id_t      out_id_o
);

    logic signed [2*rx_pkg::IQ_W-1:0] p_ic, p_qs, p_qc, p_is;
    logic signed [2*rx_pkg::IQ_W:0]   sum_i, sum_q;
    logic                             valid_1;
    rx_pkg::sample_id_t               id_1;

    // clip to the iq range
    function automatic rx_pkg::iq_t sat(input logic signed [2*rx_pkg::IQ_W:0] x);
        logic signed [2*rx_pkg::IQ_W:0] hi;
        logic signed [2*rx_pkg::IQ_W:0] lo;
        hi = (2*rx_pkg::IQ_W+1)'((1 << (rx_pkg::IQ_W - 1)) - 1);
        lo = -hi - 1;
        if (x > hi) begin
            return rx_pkg::iq_t'(hi);
        end else if (x < lo) begin
            return rx_pkg::iq_t'(lo);
        end
        return rx_pkg::iq_t'(x);
    endfunction

    // ----------------------------------------
    // stage 1, products
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rot.valid) begin
            p_ic <= rot.i * rot.cos;
            p_qs <= rot.q * rot.sin;
            p_qc <= rot.q * rot.cos;
            p_is <= rot.i * rot.sin;
            id_1 <= rot.id;
        end
    end

    // ----------------------------------------
    // stage 2, rotate by the negative phase
    // ----------------------------------------
    always_comb begin
        sum_i = p_ic + p_qs;
        sum_q = p_qc - p_is;
    end

    always_ff @(posedge clk_i) begin
        if (valid_1) begin
            out_i_o  <= sat(sum_i >>> rx_pkg::FRAC_BITS);
            out_q_o  <= sat(sum_q >>> rx_pkg::FRAC_BITS);
            out_id_o <= id_1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_1     <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            valid_1     <= rot.valid;
            out_valid_o <= valid_1;
        end
    end

endmodule

`default_nettype wire

//--- src/rx_status_regs.sv
`timescale 1ns/1ns
`default_nettype none

module rx_status_regs (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,

    input  wire logic               reg_req_i,
    input  wire rx_pkg::reg_addr_t  reg_addr_i,
    output logic                    reg_ack_o,
    output rx_pkg::reg_data_t       reg_rdata_o,

    input  wire rx_pkg::sample_id_t sample_cnt_i,
    input  wire rx_pkg::phase_t     cfo_inc_i,
    input  wire rx_pkg::phase_t     phase_i,
    input  wire logic               out_valid_i,
    input  wire rx_pkg::iq_t        out_i_i,
    input  wire rx_pkg::iq_t        out_q_i
);

    typedef enum logic {
        REG_IDLE,
        REG_ACK
    } reg_state_e;

    reg_state_e        state;
    rx_pkg::reg_data_t last_iq;
    rx_pkg::reg_data_t rd_mux;

    // last corrected sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            last_iq <= '0;
        end else if (out_valid_i) begin
            last_iq <= {out_q_i, out_i_i};
        end
    end

    always_comb begin
        case (reg_addr_i)
            rx_pkg::REG_SAMPLE_CNT: rd_mux = sample_cnt_i;
            rx_pkg::REG_CFO_INC:    rd_mux = rx_pkg::reg_data_t'(cfo_inc_i);
            rx_pkg::REG_PHASE:      rd_mux = rx_pkg::reg_data_t'(phase_i);
            rx_pkg::REG_LAST_IQ:    rd_mux = last_iq;
            default:                rd_mux = '0;
        endcase
    end

    // ----------------------------------------
    // four-phase read handshake
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= REG_IDLE;
            reg_rdata_o <= '0;
        end else begin
            case (state)
                REG_IDLE: begin
                    if (reg_req_i) begin
                        reg_rdata_o <= rd_mux;
                        state       <= REG_ACK;
                    end
                end
                REG_ACK: begin
                    // hold ack until the host lets go
                    if (!reg_req_i) begin
                        state <= REG_IDLE;
                    end
                end
                default: state <= REG_IDLE;
            endcase
        end
    end

    assign reg_ack_o = (state == REG_ACK);

endmodule

`default_nettype wire

//--- src/cfo_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module cfo_frontend (
    input  wire logic               clk_i,
    input  wire logic               reset_ni,

    // sample input
    input  wire logic               in_valid_i,
    input  wire rx_pkg::iq_t        in_i_i,
    input  wire rx_pkg::iq_t        in_q_i,

    // relative cfo estimate
    input  wire logic               cfo_valid_i,
    input  wire rx_pkg::phase_t     cfo_update_i,
    input  wire logic               manual_mode_i,

    // corrected samples
    output logic                    out_valid_o,
    output rx_pkg::iq_t             out_i_o,
    output rx_pkg::iq_t             out_q_o,
    output rx_pkg::sample_id_t      out_id_o,

    // status read port
    input  wire logic               reg_req_i,
    input  wire rx_pkg::reg_addr_t  reg_addr_i,
    output logic                    reg_ack_o,
    output rx_pkg::reg_data_t       reg_rdata_o
);

    sample_phase_if sp ();
    rotation_if     rot ();

    rx_pkg::phase_t     cfo_inc;
    rx_pkg::phase_t     phase;
    rx_pkg::sample_id_t sample_cnt;

    // ----------------------------------------
    // correction pipeline, 4 cycles
    // ----------------------------------------
    cfo_phase_accum cfo_phase_accum_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in_valid_i    (in_valid_i),
        .in_i_i        (in_i_i),
        .in_q_i        (in_q_i),
        .cfo_valid_i   (cfo_valid_i),
        .cfo_update_i  (cfo_update_i),
        .manual_mode_i (manual_mode_i),
        .sp            (sp.src),
        .cfo_inc_o     (cfo_inc),
        .phase_o       (phase),
        .sample_cnt_o  (sample_cnt)
    );

    nco_lut nco_lut_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .sp       (sp.dst),
        .rot      (rot.src)
    );

    derotator derotator_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .rot         (rot.dst),
        .out_valid_o (out_valid_o),
        .out_i_o     (out_i_o),
        .out_q_o     (out_q_o),
        .out_id_o    (out_id_o)
    );

    // ----------------------------------------
    // status registers
    // ----------------------------------------
    rx_status_regs rx_status_regs_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .reg_req_i    (reg_req_i),
        .reg_addr_i   (reg_addr_i),
        .reg_ack_o    (reg_ack_o),
        .reg_rdata_o  (reg_rdata_o),
        .sample_cnt_i (sample_cnt),
        .cfo_inc_i    (cfo_inc),
        .phase_i      (phase),
        .out_valid_i  (out_valid_o),
        .out_i_i      (out_i_o),
        .out_q_i      (out_q_o)
    );

endmodule

`default_nettype wire

//--- tb/cfo_frontend_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module cfo_frontend_assertions (
    input wire logic clk_i,
    input wire logic reset_ni,
    input wire logic reg_req_i,
    input wire logic reg_ack_o,
    input wire logic in_valid_i,
    input wire logic out_valid_o
);

    // ----------------------------------------
    // four-phase read handshake
    // ----------------------------------------
    ack_rise_on_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $rose(reg_ack_o) |-> $past(reg_req_i))
        else $error("ack rose without a pending request");

    ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!reset_ni)
        $fell(reg_ack_o) |-> $past(!reg_req_i))
        else $error("ack fell while the request was still high");

    // output valid trails the input valid by four edges
    out_latency: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_o == $past(in_valid_i, 4))
        else $error("out_valid does not follow in_valid by four cycles");

endmodule

bind cfo_frontend cfo_frontend_assertions cfo_frontend_assertions_i (
    .clk_i       (clk_i),
    .reset_ni    (reset_ni),
    .reg_req_i   (reg_req_i),
    .reg_ack_o   (reg_ack_o),
    .in_valid_i  (in_valid_i),
    .out_valid_o (out_valid_o)
);

`default_nettype wire

//--- tb/tb_cfo_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cfo_frontend;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int          N_MANUAL     = 200;
    localparam int          N_CFO        = 600;
    localparam int          N_BURST      = 100;
    localparam int          MAX_CYCLES   = RESET_CYCLES + N_MANUAL + N_CFO + N_BURST + 300;
    localparam logic [31:0] SEED         = 32'h757a245d;

    logic               clk_i = 1'b0;
    logic               reset_ni;
    logic               in_valid_i;
    rx_pkg::iq_t        in_i_i;
    rx_pkg::iq_t        in_q_i;
    logic               cfo_valid_i;
    rx_pkg::phase_t     cfo_update_i;
    logic               manual_mode_i;
    logic               out_valid_o;
    rx_pkg::iq_t        out_i_o;
    rx_pkg::iq_t        out_q_o;
    rx_pkg::sample_id_t out_id_o;
    logic               reg_req_i;
    rx_pkg::reg_addr_t  reg_addr_i;
    logic               reg_ack_o;
    rx_pkg::reg_data_t  reg_rdata_o;

    // reference model state
    logic [31:0]        lfsr;
    rx_pkg::sample_id_t m_cnt;
    rx_pkg::phase_t     m_inc;
    rx_pkg::phase_t     m_phase;
    rx_pkg::reg_data_t  m_last;
    int                 cos_ref [64];
    int                 sin_ref [64];
    logic [63:0]        exp_q [$];
    logic [3:0]         valid_hist;
    int                 errors;

    cfo_frontend uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int round_real(input real r);
        if (r >= 0.0) begin
            return $rtoi(r + 0.5);
        end
        return -$rtoi(0.5 - r);
    endfunction

    function automatic rx_pkg::iq_t clip(input longint x);
        if (x > 32767) begin
            return 16'sh7fff;
        end else if (x < -32768) begin
            return 16'sh8000;
        end
        return rx_pkg::iq_t'(x);
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_outputs();
        logic [63:0] e;
        assert (out_valid_o == valid_hist[3]) else
            report_error($sformatf("mismatch at %0t ns: out_valid %0b, expected %0b",
                                   $time, out_valid_o, valid_hist[3]));
        if (out_valid_o) begin
            assert (exp_q.size() > 0) else
                report_error("an output appeared with no sample in flight");
            e = exp_q.pop_front();
            assert ({out_id_o, out_q_o, out_i_o} == e) else
                report_error($sformatf(
                    "mismatch at %0t ns: id %0d i %0d q %0d, expected %0d %0d %0d",
                    $time, out_id_o, out_i_o, out_q_o,
                    e[63:32], $signed(e[15:0]), $signed(e[31:16])));
            m_last = e[31:0];
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        check_outputs();
    endtask

    // drive one cycle and advance the model as the DUT will at the next edge
    task automatic drive(input logic v, input rx_pkg::iq_t i, input rx_pkg::iq_t q,
                         input logic cv, input rx_pkg::phase_t upd, input logic man);
        int     c;
        int     s;
        longint ri;
        longint rq;
        in_valid_i    = v;
        in_i_i        = i;
        in_q_i        = q;
        cfo_valid_i   = cv;
        cfo_update_i  = upd;
        manual_mode_i = man;
        if (v) begin
            c  = cos_ref[m_phase[rx_pkg::PHASE_W-1 -: rx_pkg::LUT_BITS]];
            s  = sin_ref[m_phase[rx_pkg::PHASE_W-1 -: rx_pkg::LUT_BITS]];
            ri = (longint'(i) * c + longint'(q) * s) >>> 15;
            rq = (longint'(q) * c - longint'(i) * s) >>> 15;
            exp_q.push_back({m_cnt, clip(rq), clip(ri)});
            m_cnt++;
        end
        if (man) begin
            m_inc   = '0;
            m_phase = '0;
        end else begin
            if (v) begin
                m_phase = m_phase + m_inc;
            end
            if (cv) begin
                m_inc = m_inc - upd;
            end
        end
        valid_hist = {valid_hist[2:0], v};
    endtask

    task automatic drive_idle();
        drive(1'b0, '0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic random_cycle(input logic man, input logic gaps);
        logic        v;
        logic        cv;
        rx_pkg::iq_t i;
        rx_pkg::iq_t q;
        v = gaps ? (take_bits(2) != 0) : 1'b1;
        if (take_bits(3) == 0) begin
            // full scale corners drive the saturation
            i = take_bits(1) ? 16'sh7fff : 16'sh8000;
            q = take_bits(1) ? 16'sh7fff : 16'sh8000;
        end else begin
            i = take_bits(16);
            q = take_bits(16);
        end
        cv = (take_bits(3) == 0);
        next_cycle();
        drive(v, i, q, cv, rx_pkg::phase_t'(take_bits(20)), man);
    endtask

    task automatic drain();
        repeat (6) begin
            next_cycle();
            drive_idle();
        end
        assert (exp_q.size() == 0) else
            report_error("samples were lost in the pipeline");
    endtask

    task automatic read_reg(input rx_pkg::reg_addr_t a, input rx_pkg::reg_data_t exp);
        next_cycle();
        reg_addr_i = a;
        reg_req_i  = 1'b1;
        drive_idle();
        next_cycle();
        assert (reg_ack_o) else
            report_error("read ack did not rise one cycle after the request");
        assert (reg_rdata_o == exp) else
            report_error($sformatf("mismatch at %0t ns: reg %0d read %h, expected %h",
                                   $time, a, reg_rdata_o, exp));
        reg_req_i = 1'b0;
        drive_idle();
        next_cycle();
        assert (!reg_ack_o) else
            report_error("read ack did not fall after the request was dropped");
        drive_idle();
    endtask

    task automatic read_all();
        read_reg(rx_pkg::REG_SAMPLE_CNT, m_cnt);
        read_reg(rx_pkg::REG_CFO_INC, rx_pkg::reg_data_t'(m_inc));
        read_reg(rx_pkg::REG_PHASE, rx_pkg::reg_data_t'(m_phase));
        read_reg(rx_pkg::REG_LAST_IQ, m_last);
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        lfsr       = SEED;
        m_cnt      = '0;
        m_inc      = '0;
        m_phase    = '0;
        m_last     = '0;
        valid_hist = '0;
        errors     = 0;
        reset_ni   = 1'b0;
        reg_req_i  = 1'b0;
        reg_addr_i = '0;
        drive_idle();
        for (int k = 0; k < 64; k++) begin
            cos_ref[k] = round_real(32767.0 * $cos(2.0 * 3.14159265358979 * k / 64.0));
            sin_ref[k] = round_real(32767.0 * $sin(2.0 * 3.14159265358979 * k / 64.0));
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_ni = 1'b1;
        drive_idle();
        next_cycle();
        assert (!reg_ack_o) else
            report_error("reg_ack_o is high after reset");
        drive_idle();
        read_all();

        // ----------------------------------------
        // manual mode, then tracked cfo
        // ----------------------------------------
        repeat (N_MANUAL) random_cycle(1'b1, 1'b1);
        drain();
        repeat (N_CFO) random_cycle(1'b0, 1'b1);
        repeat (N_BURST) random_cycle(1'b0, 1'b0);
        drain();
        read_all();

        // one manual cycle clears the increment and the phase
        next_cycle();
        drive(1'b0, '0, '0, 1'b0, '0, 1'b1);
        drain();
        read_all();
        repeat (50) random_cycle(1'b0, 1'b1);
        drain();
        read_all();

        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
src/rx_pkg.sv
src/rx_stream_if.sv
src/cfo_phase_accum.sv
src/nco_lut.sv
src/derotator.sv
src/rx_status_regs.sv
src/cfo_frontend.sv
tb/cfo_frontend_assertions.sv
tb/tb_cfo_frontend.sv
